// ==== rtl/mm_pkg.sv ====
package mm_pkg;

  // matrix geometry, the engine is fixed at 4x4
  localparam int MAT_SIZE = 4;
  localparam int DATA_W = 8;
  // 16-bit products, sum of four needs two more bits
  localparam int ACC_W = 18;
  localparam int APB_AW = 12;

  // one unsigned matrix element
  typedef logic [DATA_W-1:0] data_t;
  // four elements packed, element 0 in the low byte
  typedef logic [MAT_SIZE*DATA_W-1:0] row_t;
  // dot product before it is cut back to 8 bits
  typedef logic [ACC_W-1:0] acc_t;
  // APB byte address
  typedef logic [APB_AW-1:0] apb_addr_t;

  // register map
  localparam apb_addr_t REG_CTRL = 12'h000;
  localparam apb_addr_t REG_NORM = 12'h004;
  localparam apb_addr_t REG_STATUS = 12'h008;

  // memory windows, MAT_SIZE words each
  localparam apb_addr_t A_BASE = 12'h040;
  localparam apb_addr_t B_BASE = 12'h050;
  localparam apb_addr_t C_BASE = 12'h060;

  // bit positions inside REG_CTRL and REG_STATUS
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_NORM_BIT = 1;
  localparam int STATUS_DONE_BIT = 0;
  localparam int STATUS_BUSY_BIT = 1;

  // run sequencer states
  typedef enum logic [1:0] {
    seq_idle,
    seq_multiply,
    seq_drain,
    seq_finish
  } seq_state_t;

endpackage

// ==== rtl/bram_if.sv ====
interface bram_if #(
  parameter int MEM_DEPTH = 4
);

  // word address wide enough for the whole memory
  localparam int AW = $clog2(MEM_DEPTH);

  logic [AW-1:0] addr;
  logic en;
  logic we;
  mm_pkg::row_t wdata;
  // valid one clock after en
  mm_pkg::row_t rdata;

  // requester side
  modport master (output addr, output en, output we, output wdata, input rdata);

  // memory side
  modport slave (input addr, input en, input we, input wdata, output rdata);

endinterface

// ==== rtl/matrix_ram.sv ====
module matrix_ram #(
  parameter int MEM_DEPTH = 4
) (
  input logic clk,
  bram_if.slave host,
  bram_if.slave eng
);

  // one full row per word
  mm_pkg::row_t mem [MEM_DEPTH];

  // both ports in one process so the array has a single writer
  // engine write lands last if both hit the same word
  always_ff @(posedge clk) begin
    if (host.en) begin
      if (host.we) begin
        mem[host.addr] <= host.wdata;
      end
      host.rdata <= mem[host.addr];
    end
    if (eng.en) begin
      if (eng.we) begin
        mem[eng.addr] <= eng.wdata;
      end
      eng.rdata <= mem[eng.addr];
    end
  end

  // host and engine side never write the same word together
  a_no_write_clash: assert property (@(posedge clk)
    !(host.en && host.we && eng.en && eng.we && (host.addr == eng.addr)));

endmodule

// ==== rtl/apb_cfg_regs.sv ====
module apb_cfg_regs #(
  parameter int MEM_DEPTH = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  mm_pkg::apb_addr_t paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  input  logic              busy,
  input  logic              done_all,
  output logic              start,
  output logic              done,
  output logic              norm_en,
  output mm_pkg::data_t     mean,
  output mm_pkg::data_t     inv_var,
  bram_if.master            a_host,
  bram_if.master            b_host,
  bram_if.master            c_host
);

  localparam int AW = $clog2(MEM_DEPTH);

  logic access;
  logic is_ctrl;
  logic is_norm;
  logic is_status;
  logic in_a;
  logic in_b;
  logic in_c;
  logic in_win;
  logic blocked;
  logic err;
  logic wr_ok;
  logic mem_rd;
  logic rd_issue;
  logic rd_wait;
  logic start_wr;
  logic [1:0] word_idx;

  // access phase of an APB transfer
  assign access = psel && penable;
  // word inside a 16-byte window
  assign word_idx = paddr[3:2];

  // address decode
  assign is_ctrl = (paddr == mm_pkg::REG_CTRL);
  assign is_norm = (paddr == mm_pkg::REG_NORM);
  assign is_status = (paddr == mm_pkg::REG_STATUS);
  assign in_a = (paddr[11:4] == mm_pkg::A_BASE[11:4]);
  assign in_b = (paddr[11:4] == mm_pkg::B_BASE[11:4]);
  assign in_c = (paddr[11:4] == mm_pkg::C_BASE[11:4]);
  assign in_win = in_a || in_b || in_c;

  // memories belong to the engine from the start pulse until done_all
  assign blocked = in_win && (busy || start);
  // unmapped, C write, or memory access during a run
  assign err = !(is_ctrl || is_norm || is_status || in_win) || (in_c && pwrite) || blocked;

  assign wr_ok = access && pwrite && !err;
  assign mem_rd = access && !pwrite && in_win && !err;
  // first cycle of a memory read while the RAM still fetches
  assign rd_issue = mem_rd && !rd_wait;
  assign start_wr = wr_ok && is_ctrl && pwdata[mm_pkg::CTRL_START_BIT];

  // errors and everything else finish in the first access cycle
  assign pready = !rd_issue;
  assign pslverr = access && err;

  // host side of the three memories
  assign a_host.addr = AW'(word_idx);
  assign a_host.en = in_a && (rd_issue || wr_ok);
  assign a_host.we = in_a && wr_ok;
  assign a_host.wdata = pwdata;

  assign b_host.addr = AW'(word_idx);
  assign b_host.en = in_b && (rd_issue || wr_ok);
  assign b_host.we = in_b && wr_ok;
  assign b_host.wdata = pwdata;

  // C is read-only from the host
  assign c_host.addr = AW'(word_idx);
  assign c_host.en = in_c && rd_issue;
  assign c_host.we = 1'b0;
  assign c_host.wdata = '0;

  // read mux with memory data arriving in the wait-state cycle
  always_comb begin
    prdata = '0;
    if (is_ctrl) begin
      prdata[mm_pkg::CTRL_NORM_BIT] = norm_en;
    end else if (is_norm) begin
      prdata[15:0] = {inv_var, mean};
    end else if (is_status) begin
      prdata[mm_pkg::STATUS_DONE_BIT] = done;
      prdata[mm_pkg::STATUS_BUSY_BIT] = busy;
    end else if (in_a) begin
      prdata = a_host.rdata;
    end else if (in_b) begin
      prdata = b_host.rdata;
    end else if (in_c) begin
      prdata = c_host.rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_wait <= 1'b0;
      start <= 1'b0;
      done <= 1'b0;
      norm_en <= 1'b0;
      mean <= '0;
      inv_var <= '0;
    end else begin
      rd_wait <= rd_issue;
      // start bit is a one-cycle pulse and never stored
      start <= start_wr;
      if (wr_ok && is_ctrl) begin
        norm_en <= pwdata[mm_pkg::CTRL_NORM_BIT];
      end
      if (wr_ok && is_norm) begin
        mean <= pwdata[7:0];
        inv_var <= pwdata[15:8];
      end
      // sticky done that the next start clears
      if (start_wr) begin
        done <= 1'b0;
      end else if (done_all) begin
        done <= 1'b1;
      end
    end
  end

  // a stalled memory read completes in the next cycle with the same transfer held
  a_one_wait_state: assert property (@(posedge clk) disable iff (reset)
    !pready |=> (access && $stable(paddr) && pready));

endmodule

// ==== rtl/run_sequencer.sv ====
module run_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic busy,
  output logic start_mat_mul,
  input  logic done_mat_mul,
  input  logic done_norm,
  output logic done_all
);

  mm_pkg::seq_state_t state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mm_pkg::seq_idle;
      start_mat_mul <= 1'b0;
    end else begin
      start_mat_mul <= 1'b0;
      case (state)
        // start only counts here
        mm_pkg::seq_idle: begin
          if (start) begin
            state <= mm_pkg::seq_multiply;
            start_mat_mul <= 1'b1;
          end
        end
        mm_pkg::seq_multiply: begin
          if (done_mat_mul) begin
            state <= mm_pkg::seq_drain;
          end
        end
        // last row still on its way into C
        mm_pkg::seq_drain: begin
          if (done_norm) begin
            state <= mm_pkg::seq_finish;
          end
        end
        mm_pkg::seq_finish: begin
          state <= mm_pkg::seq_idle;
        end
        default: begin
          state <= mm_pkg::seq_idle;
        end
      endcase
    end
  end

  // busy drops together with the done_all pulse ending
  assign busy = (state != mm_pkg::seq_idle);
  assign done_all = (state == mm_pkg::seq_finish);

  // write-back completion only ever belongs to a run in progress
  a_norm_in_run: assert property (@(posedge clk) disable iff (reset)
    done_norm |-> (state != mm_pkg::seq_idle));

endmodule

// ==== rtl/matmul_4x4.sv ====
module matmul_4x4 #(
  parameter int MEM_DEPTH = 4
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         start_mat_mul,
  output logic         done_mat_mul,
  bram_if.master       a_port,
  bram_if.master       b_port,
  output mm_pkg::row_t c_row,
  output logic         c_valid
);

  localparam int AW = $clog2(MEM_DEPTH);
  localparam int DW = mm_pkg::DATA_W;
  localparam logic [1:0] LAST_IDX = 2'(mm_pkg::MAT_SIZE - 1);

  logic b_active;
  logic a_active;
  logic [1:0] idx;
  logic b_rvalid;
  logic [1:0] b_widx;
  logic a_rvalid;
  logic a_rlast;
  mm_pkg::row_t prod_row;
  // B columns, column j holds B[k][j] in element k
  mm_pkg::row_t b_col [mm_pkg::MAT_SIZE];

  // unsigned dot product of two packed rows
  function automatic mm_pkg::acc_t dot(mm_pkg::row_t a, mm_pkg::row_t b);
    mm_pkg::acc_t sum;
    sum = '0;
    for (int k = 0; k < mm_pkg::MAT_SIZE; k++) begin
      sum += mm_pkg::acc_t'(a[k*DW +: DW]) * mm_pkg::acc_t'(b[k*DW +: DW]);
    end
    return sum;
  endfunction

  // engine only reads
  assign b_port.en = b_active;
  assign b_port.addr = AW'(idx);
  assign b_port.we = 1'b0;
  assign b_port.wdata = '0;

  assign a_port.en = a_active;
  assign a_port.addr = AW'(idx);
  assign a_port.we = 1'b0;
  assign a_port.wdata = '0;

  // returned A row against all four columns, wrapped to 8 bits
  always_comb begin
    mm_pkg::acc_t acc;
    prod_row = '0;
    for (int j = 0; j < mm_pkg::MAT_SIZE; j++) begin
      acc = dot(a_port.rdata, b_col[j]);
      prod_row[j*DW +: DW] = acc[DW-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      b_active <= 1'b0;
      a_active <= 1'b0;
      idx <= '0;
      b_rvalid <= 1'b0;
      a_rvalid <= 1'b0;
      a_rlast <= 1'b0;
      c_valid <= 1'b0;
      done_mat_mul <= 1'b0;
    end else begin
      // read data is one cycle behind the request
      b_rvalid <= b_active;
      a_rvalid <= a_active;
      a_rlast <= a_active && (idx == LAST_IDX);
      c_valid <= a_rvalid;
      done_mat_mul <= a_rvalid && a_rlast;
      if (start_mat_mul) begin
        b_active <= 1'b1;
        idx <= '0;
      end else if (b_active || a_active) begin
        idx <= idx + 2'd1;
        // B phase hands straight over to the A phase
        if (idx == LAST_IDX) begin
          b_active <= 1'b0;
          a_active <= b_active;
        end
      end
    end
  end

  // column bank and result row
  always_ff @(posedge clk) begin
    b_widx <= idx;
    if (b_rvalid) begin
      b_col[b_widx] <= b_port.rdata;
    end
    if (a_rvalid) begin
      c_row <= prod_row;
    end
  end

endmodule

// ==== rtl/norm_writer.sv ====
module norm_writer #(
  parameter int MEM_DEPTH = 4
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          norm_en,
  input  mm_pkg::data_t mean,
  input  mm_pkg::data_t inv_var,
  input  mm_pkg::row_t  c_row,
  input  logic          c_valid,
  bram_if.master        c_port,
  output logic          done_norm
);

  localparam int AW = $clog2(MEM_DEPTH);
  localparam int DW = mm_pkg::DATA_W;
  localparam logic [1:0] LAST_IDX = 2'(mm_pkg::MAT_SIZE - 1);

  mm_pkg::row_t norm_row;
  mm_pkg::row_t wr_row;
  logic wr_en;
  logic [1:0] wr_idx;

  // (e - mean) * inv_var, everything modulo 256
  function automatic mm_pkg::data_t norm_elem(mm_pkg::data_t e, mm_pkg::data_t m,
                                              mm_pkg::data_t s);
    mm_pkg::data_t diff;
    diff = e - m;
    return mm_pkg::data_t'(diff * s);
  endfunction

  always_comb begin
    norm_row = c_row;
    if (norm_en) begin
      for (int j = 0; j < mm_pkg::MAT_SIZE; j++) begin
        norm_row[j*DW +: DW] = norm_elem(c_row[j*DW +: DW], mean, inv_var);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en <= 1'b0;
      wr_idx <= '0;
    end else begin
      wr_en <= c_valid;
      // row index wraps after the fourth write
      if (wr_en) begin
        wr_idx <= wr_idx + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (c_valid) begin
      wr_row <= norm_row;
    end
  end

  // write port into C
  assign c_port.en = wr_en;
  assign c_port.we = wr_en;
  assign c_port.addr = AW'(wr_idx);
  assign c_port.wdata = wr_row;

  // fourth row going into C
  assign done_norm = wr_en && (wr_idx == LAST_IDX);

endmodule

// ==== rtl/accel_top.sv ====
module accel_top #(
  parameter int MEM_DEPTH = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  mm_pkg::apb_addr_t paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              done
);

  logic start;
  logic busy;
  logic done_all;
  logic start_mat_mul;
  logic done_mat_mul;
  logic done_norm;
  logic norm_en;
  logic c_valid;
  mm_pkg::data_t mean;
  mm_pkg::data_t inv_var;
  mm_pkg::row_t c_row;

  // host and engine port of each memory
  bram_if #(.MEM_DEPTH(MEM_DEPTH)) a_host_if ();
  bram_if #(.MEM_DEPTH(MEM_DEPTH)) a_eng_if ();
  bram_if #(.MEM_DEPTH(MEM_DEPTH)) b_host_if ();
  bram_if #(.MEM_DEPTH(MEM_DEPTH)) b_eng_if ();
  bram_if #(.MEM_DEPTH(MEM_DEPTH)) c_host_if ();
  bram_if #(.MEM_DEPTH(MEM_DEPTH)) c_eng_if ();

  matrix_ram #(.MEM_DEPTH(MEM_DEPTH)) u_ram_a (.clk(clk), .host(a_host_if), .eng(a_eng_if));
  matrix_ram #(.MEM_DEPTH(MEM_DEPTH)) u_ram_b (.clk(clk), .host(b_host_if), .eng(b_eng_if));
  matrix_ram #(.MEM_DEPTH(MEM_DEPTH)) u_ram_c (.clk(clk), .host(c_host_if), .eng(c_eng_if));

  // host register block
  apb_cfg_regs #(.MEM_DEPTH(MEM_DEPTH)) u_regs (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .busy(busy), .done_all(done_all), .start(start), .done(done),
    .norm_en(norm_en), .mean(mean), .inv_var(inv_var),
    .a_host(a_host_if), .b_host(b_host_if), .c_host(c_host_if)
  );

  run_sequencer u_seq (
    .clk(clk), .reset(reset), .start(start), .busy(busy),
    .start_mat_mul(start_mat_mul), .done_mat_mul(done_mat_mul),
    .done_norm(done_norm), .done_all(done_all)
  );

  // multiply engine reads A and B
  matmul_4x4 #(.MEM_DEPTH(MEM_DEPTH)) u_matmul (
    .clk(clk), .reset(reset),
    .start_mat_mul(start_mat_mul), .done_mat_mul(done_mat_mul),
    .a_port(a_eng_if), .b_port(b_eng_if),
    .c_row(c_row), .c_valid(c_valid)
  );

  // normalize stage owns the C write port
  norm_writer #(.MEM_DEPTH(MEM_DEPTH)) u_norm (
    .clk(clk), .reset(reset),
    .norm_en(norm_en), .mean(mean), .inv_var(inv_var),
    .c_row(c_row), .c_valid(c_valid),
    .c_port(c_eng_if), .done_norm(done_norm)
  );

endmodule

// ==== bench/clk_gen.sv ====
module clk_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset held over five rising edges, released away from the edge
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// ==== bench/accel_tb.sv ====
module accel_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // cycles allowed for pready and status polls allowed per run
  localparam int READY_LIMIT = 16;
  localparam int POLL_LIMIT = 200;
  localparam int RESET_LIMIT = 20;

  logic clk;
  logic reset;
  mm_pkg::apb_addr_t paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic done;

  int seed;
  int err_count;
  int check_count;
  int test_count;
  int test_fail;
  int test_errs;
  logic aborted;
  string test_name;
  // host-side copy of the normalize settings
  logic norm_on;
  logic [7:0] mean_v;
  logic [7:0] inv_v;
  // matrices of the random cases with b_mat[k][j] at row k column j
  int a_mat [4][4];
  int b_mat [4][4];
  // last value known to sit in each row of the A, B and C windows
  logic [31:0] mem_expect [3][4];
  logic mem_known [3][4];

  int fd;
  int n;
  string line;
  string args;
  byte code;
  logic [31:0] v0;
  logic [31:0] v1;
  logic [31:0] v2;

  clk_gen u_clk (.clk(clk), .reset(reset));

  accel_top #(.MEM_DEPTH(4)) UUT (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .done(done)
  );

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("[FAIL] %0d ns: %s, got %08h expected %08h", $time, what, got, exp);
      err_count++;
      test_errs++;
    end
  endtask

  // window number 0..2 for A, B and C, or -1 outside the memory windows
  function automatic int window_of(input mm_pkg::apb_addr_t addr);
    int w;
    w = int'(addr[11:4]) - int'(mm_pkg::A_BASE[11:4]);
    return (w >= 0 && w < 3) ? w : -1;
  endfunction

  // one APB transfer with setup and access driven on falling edges
  task automatic apb_xfer(input mm_pkg::apb_addr_t addr, input logic write,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic slverr);
    int waits;
    logic got;
    rdata = '0;
    slverr = 1'b0;
    got = 1'b0;
    waits = 0;
    if (!aborted) begin
      @(negedge clk);
      paddr = addr;
      pwrite = write;
      pwdata = wdata;
      psel = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      // slave outputs taken mid-cycle, settled before the rising edge ends the transfer
      while (!got && waits < READY_LIMIT) begin
        #5;
        if (pready) begin
          rdata = prdata;
          slverr = pslverr;
          got = 1'b1;
        end
        @(negedge clk);
        waits++;
      end
      psel = 1'b0;
      penable = 1'b0;
      if (!got) begin
        $display("timeout: no pready within %0d cycles at address %03h", READY_LIMIT, addr);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic reg_write(input mm_pkg::apb_addr_t addr, input logic [31:0] data);
    logic [31:0] rd;
    logic err;
    int w;
    apb_xfer(addr, 1'b1, data, rd, err);
    check_eq($sformatf("pslverr on write to %03h", addr), err, 1'b0);
    w = window_of(addr);
    if (w >= 0) begin
      mem_expect[w][addr[3:2]] = data;
      mem_known[w][addr[3:2]] = 1'b1;
    end
  endtask

  task automatic reg_check(input mm_pkg::apb_addr_t addr, input logic [31:0] exp,
                           input string what);
    logic [31:0] rd;
    logic err;
    int w;
    apb_xfer(addr, 1'b0, 32'h0, rd, err);
    check_eq($sformatf("pslverr on read of %03h", addr), err, 1'b0);
    check_eq(what, rd, exp);
    w = window_of(addr);
    if (w >= 0) begin
      mem_expect[w][addr[3:2]] = exp;
      mem_known[w][addr[3:2]] = 1'b1;
    end
  endtask

  task automatic expect_error(input mm_pkg::apb_addr_t addr, input logic write,
                              input logic [31:0] data);
    logic [31:0] rd;
    logic err;
    apb_xfer(addr, write, data, rd, err);
    check_eq($sformatf("missing pslverr at %03h", addr), err, 1'b1);
  endtask

  // every memory row with a known value still holds it
  task automatic check_memories_kept();
    for (int w = 0; w < 3; w++) begin
      for (int r = 0; r < 4; r++) begin
        if (mem_known[w][r]) begin
          reg_check(mm_pkg::apb_addr_t'(mm_pkg::A_BASE + w * 16 + r * 4), mem_expect[w][r],
                    $sformatf("window %0d row %0d kept", w, r));
        end
      end
    end
  endtask

  // start a run and optionally poke a memory while busy before polling status until done
  task automatic run_and_wait(input logic busy_access, input mm_pkg::apb_addr_t addr,
                              input logic [31:0] data);
    logic [31:0] rd;
    logic err;
    int polls;
    // the run rewrites every C row
    for (int r = 0; r < 4; r++) begin
      mem_known[2][r] = 1'b0;
    end
    reg_write(mm_pkg::REG_CTRL, {30'b0, norm_on, 1'b1});
    if (busy_access) begin
      expect_error(addr, 1'b1, data);
    end
    apb_xfer(mm_pkg::REG_STATUS, 1'b0, 32'h0, rd, err);
    check_eq("status done cleared by start", rd[0], 1'b0);
    check_eq("done output cleared by start", done, 1'b0);
    reg_check(mm_pkg::REG_CTRL, {30'b0, norm_on, 1'b0}, "ctrl start bit reads 0");
    polls = 0;
    while (!aborted && !rd[0] && polls < POLL_LIMIT) begin
      apb_xfer(mm_pkg::REG_STATUS, 1'b0, 32'h0, rd, err);
      polls++;
    end
    if (!aborted && !rd[0]) begin
      $display("timeout: run not done after %0d status polls", POLL_LIMIT);
      aborted = 1'b1;
    end else if (!aborted) begin
      check_eq("status busy clear after done", rd[1], 1'b0);
      check_eq("done output set after run", done, 1'b1);
    end
  endtask

  task automatic finish_test();
    if (test_name != "") begin
      test_count++;
      if (test_errs == 0) begin
        $display("test %s: ok", test_name);
      end else begin
        test_fail++;
        $display("test %s: %0d errors", test_name, test_errs);
      end
    end
    test_name = "";
    test_errs = 0;
  endtask

  task automatic start_test(input string name);
    finish_test();
    test_name = name;
  endtask

  // wrapped dot products followed by the optional wrapped normalize
  function automatic logic [31:0] model_row(input int i);
    logic [31:0] row;
    int sum;
    int c;
    row = '0;
    for (int j = 0; j < 4; j++) begin
      sum = 0;
      for (int k = 0; k < 4; k++) begin
        sum += a_mat[i][k] * b_mat[k][j];
      end
      c = sum & 255;
      if (norm_on) begin
        c = ((c - int'(mean_v)) * int'(inv_v)) & 255;
      end
      row[j*8 +: 8] = c[7:0];
    end
    return row;
  endfunction

  task automatic random_case(input int idx);
    logic [31:0] packed_row;
    start_test($sformatf("random %0d", idx));
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 4; k++) begin
        a_mat[i][k] = $random(seed) & 255;
        b_mat[i][k] = $random(seed) & 255;
      end
    end
    norm_on = $random(seed) & 1;
    mean_v = $random(seed) & 255;
    inv_v = $random(seed) & 255;
    reg_write(mm_pkg::REG_NORM, {16'b0, inv_v, mean_v});
    reg_write(mm_pkg::REG_CTRL, {30'b0, norm_on, 1'b0});
    // A goes in by rows and B by columns
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 4; k++) begin
        packed_row[k*8 +: 8] = a_mat[i][k][7:0];
      end
      reg_write(mm_pkg::apb_addr_t'(mm_pkg::A_BASE + i * 4), packed_row);
      for (int k = 0; k < 4; k++) begin
        packed_row[k*8 +: 8] = b_mat[k][i][7:0];
      end
      reg_write(mm_pkg::apb_addr_t'(mm_pkg::B_BASE + i * 4), packed_row);
    end
    run_and_wait(1'b0, '0, '0);
    for (int i = 0; i < 4; i++) begin
      reg_check(mm_pkg::apb_addr_t'(mm_pkg::C_BASE + i * 4), model_row(i),
                $sformatf("random C row %0d", i));
    end
  endtask

  initial begin
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    seed = 50848;
    err_count = 0;
    check_count = 0;
    test_count = 0;
    test_fail = 0;
    test_errs = 0;
    aborted = 1'b0;
    test_name = "";
    norm_on = 1'b0;
    mean_v = '0;
    inv_v = '0;
    for (int w = 0; w < 3; w++) begin
      for (int r = 0; r < 4; r++) begin
        mem_expect[w][r] = '0;
        mem_known[w][r] = 1'b0;
      end
    end

    n = 0;
    while (reset !== 1'b0 && n < RESET_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (reset !== 1'b0) begin
      $display("reset never released by the clock generator");
      aborted = 1'b1;
    end

    fd = $fopen("bench/accel_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/accel_tests.txt");
      aborted = 1'b1;
    end

    // one record per line where the first character picks the action
    while (!aborted && fd != 0 && $fgets(line, fd) != 0) begin
      while (line.len() > 0 && (line.getc(line.len() - 1) == "\n" ||
                                line.getc(line.len() - 1) == "\r")) begin
        line = line.substr(0, line.len() - 2);
      end
      if (line.len() == 0 || line.getc(0) == "#") begin
        continue;
      end
      code = line.getc(0);
      args = line.substr(1, line.len() - 1);
      v0 = '0;
      v1 = '0;
      v2 = '0;
      n = $sscanf(args, "%h %h %h", v0, v1, v2);
      case (code)
        "T": start_test(line.substr(2, line.len() - 1));
        "A": reg_write(mm_pkg::apb_addr_t'(mm_pkg::A_BASE + v0 * 4), v1);
        "B": reg_write(mm_pkg::apb_addr_t'(mm_pkg::B_BASE + v0 * 4), v1);
        "C": reg_check(mm_pkg::apb_addr_t'(mm_pkg::C_BASE + v0 * 4), v1,
                       $sformatf("C row %0d", v0));
        "N": begin
          norm_on = v0[0];
          mean_v = v1[7:0];
          inv_v = v2[7:0];
          reg_write(mm_pkg::REG_NORM, {16'b0, inv_v, mean_v});
          reg_write(mm_pkg::REG_CTRL, {30'b0, norm_on, 1'b0});
        end
        "R": run_and_wait(1'b0, '0, '0);
        "Y": begin
          run_and_wait(1'b1, mm_pkg::apb_addr_t'(v0), v1);
          check_memories_kept();
        end
        "W": reg_write(mm_pkg::apb_addr_t'(v0), v1);
        "K": reg_check(mm_pkg::apb_addr_t'(v0), v1, $sformatf("read of %03h", v0));
        "E": begin
          expect_error(mm_pkg::apb_addr_t'(v0), v1[0], v2);
          check_memories_kept();
        end
        "X": begin
          for (int r = 0; r < v0; r++) begin
            random_case(r);
          end
        end
        default: begin
          $display("unknown record in test file: %s", line);
          err_count++;
          test_errs++;
        end
      endcase
    end
    finish_test();
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             test_count, test_fail, check_count, err_count);
    if (err_count == 0 && !aborted) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== bench/accel_tests.txt ====
# T name | A/B/C index row | N en mean inv_var | R run | W/K addr data | X count
# E addr write data expects pslverr | Y addr data writes while busy after a start
T regs
K 008 00000000
W 000 00000002
K 000 00000002
W 004 0000ab07
K 004 0000ab07
W 000 00000000
K 000 00000000
T plain
A 0 04030201
A 1 08070605
A 2 01000000
A 3 10101010
B 0 00000001
B 1 01010101
B 2 02020202
B 3 10000000
N 0 00 00
R
C 0 40140a01
C 1 80341a05
C 2 10020100
C 3 00804010
T norm
N 1 01 03
R
C 0 bd391b00
C 1 7d994b0c
C 2 2d0300fd
C 3 fd7dbd2d
T rerun
N 0 00 00
A 0 00000002
A 1 00000200
A 2 00020000
A 3 02000000
R
C 0 00040202
C 1 00040200
C 2 00040200
C 3 20040200
T errors
E 100 1 ffffffff
E 0ff 0 00000000
E 060 1 ffffffff
Y 044 12345678
K 044 00000200
C 0 00040202
C 3 20040200
T random
X 4

// ==== filelist.f ====
rtl/mm_pkg.sv
rtl/bram_if.sv
rtl/matrix_ram.sv
rtl/apb_cfg_regs.sv
rtl/run_sequencer.sv
rtl/matmul_4x4.sv
rtl/norm_writer.sv
rtl/accel_top.sv
bench/clk_gen.sv
bench/accel_tb.sv
